//--- Bender.yml
package:
  name: if_stage

sources:
  - if_pkg.sv
  - if_pc_select.sv
  - if_fetch_buffer.sv
  - if_id_regs.sv
  - if_stage.sv
  - target: test
    files:
      - tb_if_stage.sv

//--- if_fetch_buffer.sv
/*
 * Prefetch buffer. Issues word requests on the instruction bus, queues
 * the responses and presents one aligned instruction at a time, with
 * compressed and word-straddling instructions handled.
 */

`timescale 1ns/1ps

module if_fetch_buffer #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           branch_i,
  input  if_pkg::addr_t  branch_addr_i,
  input  logic           ready_i,
  output logic           instr_req_o,
  output if_pkg::addr_t  instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  if_pkg::instr_t instr_rdata_i,
  input  logic           instr_bus_err_i,
  output logic           valid_o,
  output if_pkg::instr_t rdata_o,
  output if_pkg::addr_t  addr_o,
  output logic           compressed_o,
  output logic           err_o,
  output logic           err_plus2_o,
  output logic           busy_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned XLEN = if_pkg::XLEN;

  logic                started_q;
  if_pkg::addr_t       req_addr_q;
  if_pkg::addr_t       pc_q;
  logic [CntW-1:0]     out_cnt_q;
  logic [CntW-1:0]     discard_cnt_q;
  logic [CntW-1:0]     fifo_cnt_q;
  logic [CntW-1:0]     wr_idx;
  logic [CntW:0]       pending;
  // queue entry, bus error flag above the word
  logic [XLEN:0]       fifo_q [FifoDepth];
  logic [XLEN:0]       fifo_d [FifoDepth];
  logic                req_fire;
  logic                push;
  logic                pop;
  logic                accept;
  logic                aligned;
  logic                need_word1;
  if_pkg::instr_t      word0;
  if_pkg::instr_t      word1;
  logic                err0;
  logic                err1;
  logic [15:0]         lo_half;

  ////////////////////
  // bus requests
  // words in the queue plus words still on the bus, stale ones included
  assign pending  = {1'b0, fifo_cnt_q} + {1'b0, out_cnt_q};
  // nothing goes out before the first redirect, and never in a redirect cycle
  assign instr_req_o  = req_i & started_q & ~branch_i & (pending < FifoDepth);
  assign instr_addr_o = req_addr_q;
  assign req_fire     = instr_req_o & instr_gnt_i;
  assign busy_o       = (out_cnt_q != '0);

  // responses owed to a flushed stream are dropped
  assign push = instr_rvalid_i & (discard_cnt_q == '0) & ~branch_i;

  ////////////////////
  // alignment
  assign word0   = fifo_q[0][XLEN-1:0];
  assign err0    = fifo_q[0][XLEN];
  assign word1   = fifo_q[1][XLEN-1:0];
  assign err1    = fifo_q[1][XLEN];
  assign aligned = ~pc_q[1];
  assign lo_half = aligned ? word0[15:0] : word0[31:16];

  assign compressed_o = (lo_half[1:0] != 2'b11);

  // a straddling instruction needs the next word too, unless the first one already failed
  assign need_word1 = ~aligned & ~compressed_o & ~err0;
  assign valid_o    = (fifo_cnt_q != '0) & (~need_word1 | (fifo_cnt_q > CntW'(1)));

  // compressed instructions come out zero extended
  assign rdata_o = compressed_o ? {{(XLEN-16){1'b0}}, lo_half} :
                   aligned      ? word0 : {word1[15:0], word0[31:16]};

  assign addr_o      = pc_q;
  assign err_o       = err0 | (need_word1 & err1);
  assign err_plus2_o = need_word1 & err1;

  assign accept = valid_o & ready_i;
  // a word is used up unless a compressed instruction leaves its upper half behind
  assign pop    = accept & (pc_q[1] | ~compressed_o);
  assign wr_idx = fifo_cnt_q - CntW'(pop);

  ////////////////////
  // word queue, head at entry 0
  always_comb begin
    int unsigned src;
    for (int unsigned i = 0; i < FifoDepth; i++) begin
      src = (pop && (i + 1 < FifoDepth)) ? i + 1 : i;
      fifo_d[i] = fifo_q[src];
    end
    if (push) begin
      fifo_d[wr_idx] = {instr_bus_err_i, instr_rdata_i};
    end
  end

  always_ff @(posedge clk_i) begin
    fifo_q <= fifo_d;
  end

  ////////////////////
  // control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q     <= 1'b0;
      req_addr_q    <= '0;
      pc_q          <= '0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
      fifo_cnt_q    <= '0;
    end else begin
      out_cnt_q <= out_cnt_q + CntW'(req_fire) - CntW'(instr_rvalid_i);
      if (branch_i) begin
        started_q  <= 1'b1;
        req_addr_q <= {branch_addr_i[XLEN-1:2], 2'b00};
        pc_q       <= branch_addr_i;
        fifo_cnt_q <= '0;
        // no grant this cycle, so every response still owed is stale
        discard_cnt_q <= out_cnt_q - CntW'(instr_rvalid_i);
      end else begin
        if (req_fire) begin
          req_addr_q <= req_addr_q + if_pkg::addr_t'(4);
        end
        if (accept) begin
          pc_q <= pc_q + (compressed_o ? if_pkg::addr_t'(2) : if_pkg::addr_t'(4));
        end
        fifo_cnt_q <= fifo_cnt_q + CntW'(push) - CntW'(pop);
        if (instr_rvalid_i && (discard_cnt_q != '0)) begin
          discard_cnt_q <= discard_cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

//--- if_id_regs.sv
/*
 * IF-ID pipeline register. Holds the fetched instruction for decode
 * together with its valid and new flags and the fetch error bits.
 */

`timescale 1ns/1ps

module if_id_regs (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           fetch_valid_i,
  input  if_pkg::instr_t fetch_rdata_i,
  input  if_pkg::addr_t  fetch_addr_i,
  input  logic           fetch_compressed_i,
  input  logic           fetch_err_i,
  input  logic           fetch_err_plus2_i,
  input  logic           id_in_ready_i,
  input  logic           pc_set_i,
  input  logic           instr_valid_clear_i,
  output logic           fetch_ready_o,
  output logic           instr_valid_id_o,
  output logic           instr_new_id_o,
  output if_pkg::instr_t instr_rdata_id_o,
  output logic [15:0]    instr_rdata_c_id_o,
  output logic           instr_is_compressed_id_o,
  output logic           illegal_c_insn_id_o,
  output logic           instr_fetch_err_o,
  output logic           instr_fetch_err_plus2_o,
  output if_pkg::addr_t  pc_id_o
);

  logic accept;
  logic valid_d;
  logic illegal_c;

  // decode takes an instruction whenever it is ready
  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;

  // a capture during a redirect is squashed, otherwise valid holds until cleared
  assign valid_d = (accept & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  // all-zero 16-bit encoding is the defined illegal instruction
  // (the fault from the bus takes precedence)
  assign illegal_c = fetch_compressed_i & (fetch_rdata_i[15:0] == 16'h0000) & ~fetch_err_i;

  ////////////////////
  // flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= accept;
    end
  end

  ////////////////////
  // payload, frozen while decode stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o         <= '0;
      instr_rdata_c_id_o       <= '0;
      instr_is_compressed_id_o <= 1'b0;
      illegal_c_insn_id_o      <= 1'b0;
      instr_fetch_err_o        <= 1'b0;
      instr_fetch_err_plus2_o  <= 1'b0;
      pc_id_o                  <= '0;
    end else if (accept) begin
      instr_rdata_id_o         <= fetch_rdata_i;
      instr_rdata_c_id_o       <= fetch_rdata_i[15:0];
      instr_is_compressed_id_o <= fetch_compressed_i;
      illegal_c_insn_id_o      <= illegal_c;
      instr_fetch_err_o        <= fetch_err_i;
      instr_fetch_err_plus2_o  <= fetch_err_plus2_i;
      pc_id_o                  <= fetch_addr_i;
    end
  end

endmodule

//--- if_pc_select.sv
/*
 * Next fetch address selection.
 * Picks the new PC from boot, jump, trap and return sources and
 * pulses the mtvec init request on a boot redirect.
 */

`timescale 1ns/1ps

module if_pc_select #(
  parameter if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       branch_target_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                irq_int_i,
  input  if_pkg::irq_id_t     irq_id_i,
  output if_pkg::addr_t       branch_addr_o,
  output logic                csr_mtvec_init_o
);

  localparam int unsigned BootW = $bits(if_pkg::BOOT_OFFSET);

  if_pkg::addr_t   exc_base;
  if_pkg::addr_t   exc_pc;
  if_pkg::addr_t   fetch_addr_n;
  if_pkg::irq_id_t irq_vec;

  // mtvec base with the vector field cleared
  assign exc_base = {csr_mtvec_i[if_pkg::XLEN-1:if_pkg::VEC_ALIGN_BITS],
                     {if_pkg::VEC_ALIGN_BITS{1'b0}}};

  // internal interrupts (nmi-like) all land on one vector slot
  assign irq_vec = irq_int_i ? if_pkg::IRQ_NM_ID : irq_id_i;

  ////////////////////
  // trap target
  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = exc_base;
      // one word per vector slot
      if_pkg::EXC_PC_IRQ:     exc_pc = exc_base + (if_pkg::addr_t'(irq_vec) << 2);
      if_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                exc_pc = exc_base;
    endcase
  end

  ////////////////////
  // new PC mux
  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: fetch_addr_n = {boot_addr_i[if_pkg::XLEN-1:BootW], if_pkg::BOOT_OFFSET};
      if_pkg::PC_JUMP: fetch_addr_n = branch_target_i;
      if_pkg::PC_EXC:  fetch_addr_n = exc_pc;
      if_pkg::PC_ERET: fetch_addr_n = csr_mepc_i;
      if_pkg::PC_DRET: fetch_addr_n = csr_depc_i;
      default:         fetch_addr_n = {boot_addr_i[if_pkg::XLEN-1:BootW], if_pkg::BOOT_OFFSET};
    endcase
  end

  // instructions are at least halfword aligned
  assign branch_addr_o = {fetch_addr_n[if_pkg::XLEN-1:1], 1'b0};

  // csr file loads its mtvec reset value on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

//--- if_pkg.sv
/*
 * Shared types and constants of the instruction fetch stage.
 * Every fetch module refers to these by package scope.
 */

package if_pkg;

  // address and instruction width
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] instr_t;

  // source of a new PC
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // handler target on PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // interrupt vector index, internal interrupts all share the top slot
  typedef logic [4:0] irq_id_t;
  localparam irq_id_t IRQ_NM_ID = 5'd31;

  // low byte of the reset PC, and mtvec bits replaced by the vector offset
  localparam logic [7:0]  BOOT_OFFSET    = 8'h80;
  localparam int unsigned VEC_ALIGN_BITS = 8;

endpackage

//--- if_stage.sv
/*
 * Instruction fetch stage top level. Chains PC selection, the prefetch
 * buffer and the IF-ID register, and sets their parameters.
 */

`timescale 1ns/1ps

module if_stage #(
  parameter if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned   FifoDepth       = 3
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  // instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_bus_err_i,
  // PC sources and control
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       branch_target_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                irq_int_i,
  input  if_pkg::irq_id_t     irq_id_i,
  output logic                csr_mtvec_init_o,
  // decode side
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::instr_t      instr_rdata_id_o,
  output logic [15:0]         instr_rdata_c_id_o,
  output logic                instr_is_compressed_id_o,
  output logic                illegal_c_insn_id_o,
  output logic                instr_fetch_err_o,
  output logic                instr_fetch_err_plus2_o,
  output if_pkg::addr_t       pc_id_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                if_busy_o
);

  if_pkg::addr_t  branch_addr;
  logic           fetch_valid;
  logic           fetch_ready;
  if_pkg::instr_t fetch_rdata;
  logic           fetch_compressed;
  logic           fetch_err;
  logic           fetch_err_plus2;

  // next PC, only taken by the buffer in a pc_set_i cycle
  if_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) pc_select_inst (
    .boot_addr_i      (boot_addr_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .branch_target_i  (branch_target_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_int_i        (irq_int_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // the buffer output address doubles as the IF stage PC
  if_fetch_buffer #(
    .FifoDepth (FifoDepth)
  ) fetch_buffer_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (branch_addr),
    .ready_i         (fetch_ready),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .valid_o         (fetch_valid),
    .rdata_o         (fetch_rdata),
    .addr_o          (pc_if_o),
    .compressed_o    (fetch_compressed),
    .err_o           (fetch_err),
    .err_plus2_o     (fetch_err_plus2),
    .busy_o          (if_busy_o)
  );

  if_id_regs id_regs_inst (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .fetch_valid_i            (fetch_valid),
    .fetch_rdata_i            (fetch_rdata),
    .fetch_addr_i             (pc_if_o),
    .fetch_compressed_i       (fetch_compressed),
    .fetch_err_i              (fetch_err),
    .fetch_err_plus2_i        (fetch_err_plus2),
    .id_in_ready_i            (id_in_ready_i),
    .pc_set_i                 (pc_set_i),
    .instr_valid_clear_i      (instr_valid_clear_i),
    .fetch_ready_o            (fetch_ready),
    .instr_valid_id_o         (instr_valid_id_o),
    .instr_new_id_o           (instr_new_id_o),
    .instr_rdata_id_o         (instr_rdata_id_o),
    .instr_rdata_c_id_o       (instr_rdata_c_id_o),
    .instr_is_compressed_id_o (instr_is_compressed_id_o),
    .illegal_c_insn_id_o      (illegal_c_insn_id_o),
    .instr_fetch_err_o        (instr_fetch_err_o),
    .instr_fetch_err_plus2_o  (instr_fetch_err_plus2_o),
    .pc_id_o                  (pc_id_o)
  );

endmodule

//--- tb.f
if_pkg.sv
if_pc_select.sv
if_fetch_buffer.sv
if_id_regs.sv
if_stage.sv
tb_if_stage.sv

//--- tb_if_stage.sv
/*
 * Directed testbench for the instruction fetch stage. A bus memory model
 * answers the fetch requests, and a reference walk over the same memory
 * predicts every instruction that reaches the IF-ID register.
 */

`timescale 1ns/1ps

module tb_if_stage;

  localparam int unsigned   FifoDepth       = 3;
  localparam if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800;
  localparam if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808;
  localparam if_pkg::addr_t MemBase         = 32'h0000_1000;
  localparam int            NumTests        = 6;

  logic                clk_i;
  logic                rst_ni;
  logic                req_i;
  logic                instr_req_o;
  if_pkg::addr_t       instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  if_pkg::instr_t      instr_rdata_i;
  logic                instr_bus_err_i;
  if_pkg::addr_t       boot_addr_i;
  if_pkg::addr_t       csr_mtvec_i;
  if_pkg::addr_t       csr_mepc_i;
  if_pkg::addr_t       csr_depc_i;
  if_pkg::addr_t       branch_target_i;
  logic                pc_set_i;
  if_pkg::pc_sel_e     pc_mux_i;
  if_pkg::exc_pc_sel_e exc_pc_mux_i;
  logic                irq_int_i;
  if_pkg::irq_id_t     irq_id_i;
  logic                csr_mtvec_init_o;
  logic                id_in_ready_i;
  logic                instr_valid_clear_i;
  logic                instr_valid_id_o;
  logic                instr_new_id_o;
  if_pkg::instr_t      instr_rdata_id_o;
  logic [15:0]         instr_rdata_c_id_o;
  logic                instr_is_compressed_id_o;
  logic                illegal_c_insn_id_o;
  logic                instr_fetch_err_o;
  logic                instr_fetch_err_plus2_o;
  if_pkg::addr_t       pc_id_o;
  if_pkg::addr_t       pc_if_o;
  logic                if_busy_o;

  // memory window 0x1000..0x13ff, everything else reads a fill pattern
  if_pkg::instr_t mem [256];
  logic           err_mem [256];
  logic [31:0]    rng_state = 32'h2521_9e44;

  // bus model bookkeeping, one entry per granted word
  if_pkg::addr_t  addr_q [$];
  int             gen_q [$];
  int             due_q [$];
  int             rv_gen;
  int             cur_gen;
  int             cyc;
  int             grants_total;
  int             rvalid_total;
  int             fresh_words;

  // reference walk
  if_pkg::addr_t  exp_pc;
  if_pkg::addr_t  start_pc;
  int             captures;

  if_stage #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr),
    .FifoDepth       (FifoDepth)
  ) if_stage_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // helpers
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic if_pkg::instr_t fill_word(input if_pkg::addr_t addr);
    // low bits 11 so fill words decode as 32-bit instructions
    return ((addr * 32'h9E37_79B1) ^ 32'h2C6B_1F00) | 32'h0000_0003;
  endfunction

  function automatic if_pkg::instr_t mem_read(input if_pkg::addr_t addr);
    if (addr[31:10] == MemBase[31:10]) begin
      return mem[addr[9:2]];
    end
    return fill_word({addr[31:2], 2'b00});
  endfunction

  function automatic logic err_read(input if_pkg::addr_t addr);
    return (addr[31:10] == MemBase[31:10]) ? err_mem[addr[9:2]] : 1'b0;
  endfunction

  function automatic logic [15:0] half_at(input if_pkg::addr_t addr);
    if_pkg::instr_t w;
    w = mem_read(addr);
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic addr_compare(input string what, input if_pkg::addr_t got,
                              input if_pkg::addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic instr_compare(input string what, input if_pkg::instr_t got,
                               input if_pkg::instr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic half_compare(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic bit_compare(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  ////////////////////
  // instruction bus memory
  always @(posedge clk_i) begin : bus_memory
    logic [31:0]   r;
    int            due;
    if_pkg::addr_t raddr;
    int            rgen;
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
    end else begin
      cyc++;
      if (instr_rvalid_i) begin
        rvalid_total++;
        // a response owed to the current stream lands in the queue
        if (rv_gen == cur_gen && !pc_set_i) begin
          fresh_words++;
        end
      end
      if (pc_set_i) begin
        cur_gen++;
        fresh_words = 0;
      end
      if (instr_req_o && instr_gnt_i) begin
        grants_total++;
        r   = lcg_next();
        due = cyc + int'(r[23:16]) % 3;
        // responses stay in grant order
        if (due_q.size() > 0 && due <= due_q[$]) begin
          due = due_q[$] + 1;
        end
        addr_q.push_back(instr_addr_o);
        gen_q.push_back(cur_gen);
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        raddr = addr_q.pop_front();
        rgen  = gen_q.pop_front();
        due   = due_q.pop_front();
        instr_rvalid_i  <= 1'b1;
        instr_rdata_i   <= mem_read(raddr);
        instr_bus_err_i <= err_read(raddr);
        rv_gen          <= rgen;
      end else begin
        instr_rvalid_i  <= 1'b0;
        instr_bus_err_i <= 1'b0;
      end
      r = lcg_next();
      instr_gnt_i <= (r[21:20] != 2'b00);
    end
  end

  ////////////////////
  // reference walk over each captured instruction
  always @(negedge clk_i) begin : capture_check
    logic [15:0]    lo;
    logic           comp;
    logic           straddle;
    logic           err0;
    logic           err1;
    if_pkg::instr_t exp_data;
    int             pending;
    if (rst_ni && instr_new_id_o && instr_valid_id_o) begin
      lo       = half_at(exp_pc);
      comp     = (lo[1:0] != 2'b11);
      straddle = exp_pc[1] & ~comp;
      err0     = err_read(exp_pc);
      // the second word only matters when the first one came back clean
      err1     = straddle & ~err0 & err_read(exp_pc + 32'd2);
      exp_data = comp ? {16'h0000, lo} : {half_at(exp_pc + 32'd2), lo};
      addr_compare("pc_id_o", pc_id_o, exp_pc);
      instr_compare("instr_rdata_id_o", instr_rdata_id_o, exp_data);
      half_compare("instr_rdata_c_id_o", instr_rdata_c_id_o, lo);
      bit_compare("instr_is_compressed_id_o", instr_is_compressed_id_o, comp);
      bit_compare("illegal_c_insn_id_o", illegal_c_insn_id_o,
                  comp & (lo == 16'h0000) & ~(err0 | err1));
      bit_compare("instr_fetch_err_o", instr_fetch_err_o, err0 | err1);
      bit_compare("instr_fetch_err_plus2_o", instr_fetch_err_plus2_o, err1);
      exp_pc = exp_pc + (comp ? 32'd2 : 32'd4);
      // the fetch address has moved on to the next instruction
      addr_compare("pc_if_o", pc_if_o, exp_pc);
      captures++;
    end
    // busy while any granted word is still owed by the bus
    if (rst_ni) begin
      bit_compare("if_busy_o", if_busy_o, grants_total != rvalid_total);
    end
    // words on the bus plus words granted to this stream and not yet used
    if (rst_ni && instr_req_o) begin
      bit_compare("instr_addr_o word aligned", instr_addr_o[1:0] == 2'b00, 1'b1);
      pending = (grants_total - rvalid_total) + fresh_words
                - (int'(exp_pc[31:2]) - int'(start_pc[31:2]));
      if (pending >= FifoDepth) begin
        abort_run("instr_req_o is high while the prefetch queue is full");
      end
    end
  end

  ////////////////////
  // stimulus
  task automatic redirect_to(input if_pkg::pc_sel_e sel, input if_pkg::exc_pc_sel_e exc,
                             input if_pkg::addr_t target);
    @(posedge clk_i);
    pc_set_i     <= 1'b1;
    pc_mux_i     <= sel;
    exc_pc_mux_i <= exc;
    @(negedge clk_i);
    bit_compare("csr_mtvec_init_o", csr_mtvec_init_o, sel == if_pkg::PC_BOOT);
    bit_compare("instr_req_o in pc_set cycle", instr_req_o, 1'b0);
    @(posedge clk_i);
    pc_set_i <= 1'b0;
    exp_pc   = target;
    start_pc = target;
    @(negedge clk_i);
    bit_compare("csr_mtvec_init_o after pc_set", csr_mtvec_init_o, 1'b0);
  endtask

  task automatic wait_captures(input int n);
    int target;
    target = captures + n;
    while (captures < target) begin
      @(posedge clk_i);
    end
  endtask

  task automatic boot_sequence();
    // nothing may be fetched before the first new PC
    repeat (3) begin
      @(negedge clk_i);
      bit_compare("instr_req_o before first pc_set", instr_req_o, 1'b0);
    end
    redirect_to(if_pkg::PC_BOOT, if_pkg::EXC_PC_EXC, {boot_addr_i[31:8], if_pkg::BOOT_OFFSET});
    wait_captures(6);
  endtask

  task automatic mixed_stream();
    // c, straddling 32-bit, c, aligned 32-bit, all-zero c, c
    mem[8'h80] = {16'h0513, 16'h4501};
    mem[8'h81] = {16'h8082, 16'h0010};
    mem[8'h82] = 32'h00A5_0593;
    mem[8'h83] = {16'h0001, 16'h0000};
    @(posedge clk_i);
    branch_target_i <= 32'h0000_1200;
    redirect_to(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_1200);
    wait_captures(8);
  endtask

  task automatic pc_sources();
    if_pkg::addr_t base;
    base = csr_mtvec_i & ~((32'd1 << if_pkg::VEC_ALIGN_BITS) - 32'd1);
    redirect_to(if_pkg::PC_ERET, if_pkg::EXC_PC_EXC, csr_mepc_i);
    wait_captures(2);
    redirect_to(if_pkg::PC_DRET, if_pkg::EXC_PC_EXC, csr_depc_i);
    wait_captures(2);
    redirect_to(if_pkg::PC_EXC, if_pkg::EXC_PC_EXC, base);
    wait_captures(2);
    @(posedge clk_i);
    irq_id_i  <= 5'd7;
    irq_int_i <= 1'b0;
    redirect_to(if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ, base + 32'd4 * 32'd7);
    wait_captures(2);
    // internal interrupts ignore irq_id_i
    @(posedge clk_i);
    irq_int_i <= 1'b1;
    redirect_to(if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ, base + 32'd4 * 32'(if_pkg::IRQ_NM_ID));
    wait_captures(2);
    redirect_to(if_pkg::PC_EXC, if_pkg::EXC_PC_DBD, DmHaltAddr);
    wait_captures(2);
    redirect_to(if_pkg::PC_EXC, if_pkg::EXC_PC_DBG_EXC, DmExceptionAddr);
    wait_captures(2);
    redirect_to(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, branch_target_i);
    wait_captures(2);
  endtask

  task automatic back_pressure();
    int stall;
    @(posedge clk_i);
    branch_target_i <= 32'h0000_1000;
    redirect_to(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_1000);
    repeat (12) begin
      wait_captures(1);
      stall = 2 + int'(lcg_next() >> 28) % 6;
      id_in_ready_i <= 1'b0;
      repeat (stall) @(posedge clk_i);
      id_in_ready_i <= 1'b1;
    end
  endtask

  task automatic bus_errors();
    // faulty aligned word, clean c, straddle failing on its second word
    mem[8'hC0]     = 32'h0020_0093;
    err_mem[8'hC0] = 1'b1;
    mem[8'hC1]     = {16'h0513, 16'h4501};
    mem[8'hC2]     = {16'h0001, 16'h0010};
    err_mem[8'hC2] = 1'b1;
    @(posedge clk_i);
    branch_target_i <= 32'h0000_1300;
    redirect_to(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_1300);
    wait_captures(6);
  endtask

  task automatic clear_and_redirect();
    @(posedge clk_i);
    branch_target_i <= 32'h0000_1000;
    redirect_to(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 32'h0000_1000);
    // from here on a captured instruction stays valid until decode clears it
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    wait_captures(2);
    id_in_ready_i <= 1'b0;
    // valid holds while decode neither clears nor takes a new one
    repeat (3) begin
      @(negedge clk_i);
      bit_compare("instr_valid_id_o while held", instr_valid_id_o, 1'b1);
    end
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    bit_compare("instr_valid_id_o after clear", instr_valid_id_o, 1'b0);
    @(posedge clk_i);
    id_in_ready_i <= 1'b1;
    wait_captures(3);
    // new target mid-stream, stale words must not show up
    redirect_to(if_pkg::PC_ERET, if_pkg::EXC_PC_EXC, csr_mepc_i);
    wait_captures(3);
  endtask

  ////////////////////
  // watchdog
  initial begin
    repeat (NumTests * 200) @(posedge clk_i);
    $display("ERROR: timeout after %0d cycles, the fetch stage stopped delivering",
             NumTests * 200);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  end

  initial begin
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    boot_addr_i         = 32'h0000_1037;
    csr_mtvec_i         = 32'h0000_1A5D;
    csr_mepc_i          = 32'h0000_1100;
    csr_depc_i          = 32'h0000_1140;
    branch_target_i     = 32'h0000_1180;
    pc_set_i            = 1'b0;
    pc_mux_i            = if_pkg::PC_BOOT;
    exc_pc_mux_i        = if_pkg::EXC_PC_EXC;
    irq_int_i           = 1'b0;
    irq_id_i            = '0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b1;
    rv_gen = 0;
    cur_gen = 0;
    cyc = 0;
    grants_total = 0;
    rvalid_total = 0;
    fresh_words = 0;
    exp_pc = '0;
    start_pc = '0;
    captures = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(MemBase + 32'(4 * i));
      err_mem[i] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    bit_compare("instr_req_o in reset", instr_req_o, 1'b0);
    bit_compare("instr_valid_id_o in reset", instr_valid_id_o, 1'b0);
    bit_compare("instr_new_id_o in reset", instr_new_id_o, 1'b0);
    bit_compare("csr_mtvec_init_o in reset", csr_mtvec_init_o, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    req_i  <= 1'b1;
    boot_sequence();
    mixed_stream();
    pc_sources();
    back_pressure();
    bus_errors();
    clear_and_redirect();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
